/* src/usb_rx_macros.svh */
/* Receiver timing constants shared by all lanes.
   USB_NUM_PORTS must stay a power of two for the collector pointer wrap. */
`ifndef USB_RX_MACROS_SVH
`define USB_RX_MACROS_SVH

// Clocks in one bit time, full speed at 8x oversampling
`define USB_CLKS_PER_BIT 8

`define USB_NUM_PORTS 4

// Consecutive ones before the transmitter inserts a zero
`define USB_STUFF_LIMIT 6

// Edgeless bit times that close a packet
`define USB_IDLE_BITS 8

`endif

/* src/usb_rx_pkg.sv */
/* Types shared by the receive lanes, the collector and the top level.
   port_id_t is sized for four ports. */
package usb_rx_pkg;

	// One received byte, bit 0 first on the wire
	typedef logic [7:0] usb_byte_t;

	// Lane number carried with each output byte
	typedef logic [1:0] port_id_t;

	// Lane activity, IDLE until a J to K transition opens a packet
	typedef enum logic {
		IDLE,
		RECEIVING
	} lane_state_t;

endpackage

/* src/line_sync.sv */
/* Two-flop synchronizer plus edge detector for every port pin.
   Pins reset to 1, the idle J level, so no edge appears out of reset. */
`timescale 1ns/1ps
`include "usb_rx_macros.svh"

module line_sync (
	input  logic                       clk,
	input  logic                       n_rst,
	input  logic [`USB_NUM_PORTS-1:0] d_pin,
	output logic [`USB_NUM_PORTS-1:0] d_line,
	output logic [`USB_NUM_PORTS-1:0] d_edge
);

	logic [`USB_NUM_PORTS-1:0] meta;
	logic [`USB_NUM_PORTS-1:0] sync;
	logic [`USB_NUM_PORTS-1:0] last;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			meta <= '1;
			sync <= '1;
			last <= '1;
		end else begin
			meta <= d_pin;
			sync <= meta;
			// Previous settled level for the edge compare
			last <= sync;
		end
	end

	assign d_line = sync;
	assign d_edge = sync ^ last;

	// A real line holds each level for a full bit, never for one clock
	assert property (@(posedge clk) disable iff (!n_rst)
		(d_edge & $past(d_edge)) == '0)
		else $error("line_sync: back to back edges on one lane");

endmodule

/* src/rx_bit_timer.sv */
/* Bit timing for one lane: samples mid-bit, flags stuffed bits and ends packets.
   A packet opens only on a J to K edge and closes after USB_IDLE_BITS quiet bits. */
`timescale 1ns/1ps
`include "usb_rx_macros.svh"

module rx_bit_timer import usb_rx_pkg::*; (
	input  logic clk,
	input  logic n_rst,
	input  logic d_edge,
	input  logic d_line,
	output logic shift_enable,
	output logic stuffed,
	output logic packet_end,
	output logic receiving
);

	localparam int PHASE_W = $clog2(`USB_CLKS_PER_BIT);
	localparam int ONES_W = $clog2(`USB_STUFF_LIMIT + 1);
	localparam int IDLE_W = $clog2(`USB_IDLE_BITS);
	localparam logic [PHASE_W-1:0] MID = PHASE_W'(`USB_CLKS_PER_BIT / 2 - 1);
	localparam logic [PHASE_W-1:0] LAST = PHASE_W'(`USB_CLKS_PER_BIT - 1);

	lane_state_t        state;
	logic [PHASE_W-1:0] phase;
	logic [ONES_W-1:0]  ones_cnt;
	logic [IDLE_W-1:0]  idle_cnt;
	logic               edge_seen;
	logic               tick;

	assign receiving = (state == RECEIVING);
	assign tick = receiving && (phase == MID);
	assign packet_end = tick && !edge_seen && (idle_cnt == IDLE_W'(`USB_IDLE_BITS - 1));
	assign shift_enable = tick && !packet_end;
	// Sample right after a full run of ones carries the inserted zero
	assign stuffed = shift_enable && (ones_cnt == ONES_W'(`USB_STUFF_LIMIT));

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:
					if (d_edge && !d_line)
						state <= RECEIVING;
				RECEIVING:
					if (packet_end)
						state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// Every edge realigns the bit clock, sample lands half a bit later
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			phase <= '0;
		else if (d_edge || phase == LAST)
			phase <= '0;
		else
			phase <= phase + 1'b1;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			edge_seen <= 1'b0;
		else if (d_edge)
			edge_seen <= 1'b1;
		else if (tick)
			edge_seen <= 1'b0;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			ones_cnt <= '0;
			idle_cnt <= '0;
		end else if (!receiving) begin
			ones_cnt <= '0;
			idle_cnt <= '0;
		end else if (tick) begin
			ones_cnt <= (edge_seen || stuffed) ? '0 : ones_cnt + 1'b1;
			idle_cnt <= edge_seen ? '0 : idle_cnt + 1'b1;
		end
	end

	// Line edges belong at bit boundaries, one on the sample point means lost bit sync
	assert property (@(posedge clk) disable iff (!n_rst)
		receiving && d_edge |-> phase != MID)
		else $error("rx_bit_timer: line edge on the sample point");

endmodule

/* src/rx_lane.sv */
/* One receive lane: NRZI decode, stuffing removal and LSB-first byte assembly.
   A partial byte left at packet end is dropped, never emitted. */
`timescale 1ns/1ps

module rx_lane import usb_rx_pkg::*; (
	input  logic      clk,
	input  logic      n_rst,
	input  logic      d_edge,
	input  logic      d_line,
	output logic      lane_valid,
	output usb_byte_t lane_data
);

	logic        shift_enable;
	logic        stuffed;
	logic        packet_end;
	logic        receiving;
	lane_state_t lane_state;
	logic        prev_level;
	logic        nrzi_bit;
	logic        take_bit;
	logic [2:0]  bit_cnt;
	usb_byte_t   shift_reg;

	rx_bit_timer u_timer (
		.clk          (clk),
		.n_rst        (n_rst),
		.d_edge       (d_edge),
		.d_line       (d_line),
		.shift_enable (shift_enable),
		.stuffed      (stuffed),
		.packet_end   (packet_end),
		.receiving    (receiving)
	);

	assign lane_state = receiving ? RECEIVING : IDLE;
	assign take_bit = shift_enable && !stuffed;
	// Same level as last sample means no transition, a 1
	assign nrzi_bit = (d_line == prev_level);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			prev_level <= 1'b1;
			bit_cnt <= '0;
			lane_valid <= 1'b0;
		end else begin
			lane_valid <= take_bit && (bit_cnt == 3'd7);

			// Between packets the reference level is idle J
			if (lane_state == IDLE)
				prev_level <= 1'b1;
			else if (shift_enable)
				prev_level <= d_line;

			if (packet_end)
				bit_cnt <= '0;
			else if (take_bit)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// First bit on the wire ends up in bit 0
	always_ff @(posedge clk) begin
		if (packet_end)
			shift_reg <= '0;
		else if (take_bit)
			shift_reg <= {nrzi_bit, shift_reg[7:1]};
	end

	assign lane_data = shift_reg;

endmodule

/* src/byte_collector.sv */
/* Merges the lane byte strobes onto one output, round robin, one byte per clock.
   No back-pressure: each lane must stay below one byte per USB_NUM_PORTS clocks. */
`timescale 1ns/1ps
`include "usb_rx_macros.svh"

module byte_collector import usb_rx_pkg::*; (
	input  logic                                 clk,
	input  logic                                 n_rst,
	input  logic [`USB_NUM_PORTS-1:0]            lane_valid,
	input  usb_byte_t [`USB_NUM_PORTS-1:0]       lane_data,
	output logic                                 byte_valid,
	output usb_byte_t                            byte_data,
	output port_id_t                             byte_port
);

	localparam int N = `USB_NUM_PORTS;

	usb_byte_t [N-1:0] hold_data;
	logic [N-1:0]      full;
	logic [N-1:0]      clr_mask;
	port_id_t          ptr;
	port_id_t          sel;
	logic              found;

	// First full lane at or after the pointer
	always_comb begin
		port_id_t idx;
		idx = ptr;
		found = 1'b0;
		sel = ptr;
		for (int k = 0; k < N; k++) begin
			idx = ptr + port_id_t'(k);
			if (!found && full[idx]) begin
				found = 1'b1;
				sel = idx;
			end
		end
	end

	assign clr_mask = found ? (N'(1) << sel) : '0;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			full <= '0;
			ptr <= '0;
			byte_valid <= 1'b0;
		end else begin
			// A fresh strobe wins over the drain of the same lane
			full <= (full & ~clr_mask) | lane_valid;
			byte_valid <= found;
			if (found)
				ptr <= sel + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < N; i++) begin
			if (lane_valid[i])
				hold_data[i] <= lane_data[i];
		end
		if (found) begin
			byte_data <= hold_data[sel];
			byte_port <= sel;
		end
	end

	for (genvar i = 0; i < N; i++) begin : g_overrun
		assert property (@(posedge clk) disable iff (!n_rst)
			lane_valid[i] |-> !full[i] || clr_mask[i])
			else $error("byte_collector: lane %0d overrun", i);
	end

endmodule

/* src/usb_rx_top.sv */
/* Four-port serial receive front end, one byte strobe out with its port.
   Single-ended data pins, no SE0 detection, no CRC or PID checks. */
`timescale 1ns/1ps
`include "usb_rx_macros.svh"

module usb_rx_top import usb_rx_pkg::*; (
	input  logic                       clk,
	input  logic                       n_rst,
	input  logic [`USB_NUM_PORTS-1:0] d_pin,
	output logic                       byte_valid,
	output usb_byte_t                  byte_data,
	output port_id_t                   byte_port
);

	logic [`USB_NUM_PORTS-1:0]      d_line;
	logic [`USB_NUM_PORTS-1:0]      d_edge;
	logic [`USB_NUM_PORTS-1:0]      lane_valid;
	usb_byte_t [`USB_NUM_PORTS-1:0] lane_data;

	line_sync u_sync (
		.clk    (clk),
		.n_rst  (n_rst),
		.d_pin  (d_pin),
		.d_line (d_line),
		.d_edge (d_edge)
	);

	// One independent receiver per port
	for (genvar i = 0; i < `USB_NUM_PORTS; i++) begin : g_lane
		rx_lane u_lane (
			.clk        (clk),
			.n_rst      (n_rst),
			.d_edge     (d_edge[i]),
			.d_line     (d_line[i]),
			.lane_valid (lane_valid[i]),
			.lane_data  (lane_data[i])
		);
	end

	byte_collector u_collect (
		.clk        (clk),
		.n_rst      (n_rst),
		.lane_valid (lane_valid),
		.lane_data  (lane_data),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_port  (byte_port)
	);

endmodule

/* test/usb_rx_checker.sv */
/* Compares every output byte with the next byte queued for its port.
   Expected bytes must be queued with expect_byte before their packet is sent. */
`timescale 1ns/1ps
`include "usb_rx_macros.svh"

module usb_rx_checker import usb_rx_pkg::*; (
	input logic      clk,
	input logic      n_rst,
	input logic      byte_valid,
	input usb_byte_t byte_data,
	input port_id_t  byte_port
);

	usb_byte_t exp_q [`USB_NUM_PORTS][$];
	string     name_q [`USB_NUM_PORTS][$];
	int        checked = 0;
	int        mismatched = 0;
	int        unexpected = 0;
	int        missing = 0;

	task automatic expect_byte(input port_id_t p, input usb_byte_t b, input string name);
		exp_q[p].push_back(b);
		name_q[p].push_back(name);
	endtask

	function automatic int outstanding();
		int n;
		n = 0;
		for (int p = 0; p < `USB_NUM_PORTS; p++)
			n += exp_q[p].size();
		return n;
	endfunction

	// Bytes still queued here were lost somewhere in the DUT
	task automatic report_leftovers();
		for (int p = 0; p < `USB_NUM_PORTS; p++) begin
			if (exp_q[p].size() != 0)
				$display("%0d bytes never arrived on port %0d", exp_q[p].size(), p);
			missing += exp_q[p].size();
		end
	endtask

	function automatic int error_total();
		return mismatched + unexpected + missing;
	endfunction

	task automatic print_counts();
		$display("checked %0d bytes: %0d mismatched, %0d unexpected, %0d missing",
			checked, mismatched, unexpected, missing);
	endtask

	always @(posedge clk) begin
		usb_byte_t want;
		string     name;
		if (n_rst && byte_valid) begin
			if (exp_q[byte_port].size() == 0) begin
				unexpected++;
				$display("byte %h came out on port %0d with nothing expected there",
					byte_data, byte_port);
			end else begin
				want = exp_q[byte_port].pop_front();
				name = name_q[byte_port].pop_front();
				checked++;
				if (byte_data !== want) begin
					mismatched++;
					$display("error %s port %0d: expected %h, actual %h",
						name, byte_port, want, byte_data);
				end
			end
		end
	end

endmodule

/* test/usb_rx_tb.sv */
/* Testbench for the four-port receiver, packets come from test/usb_rx_vectors.txt.
   Run from the project root so the vector path resolves. */
`timescale 1ns/1ps
`include "usb_rx_macros.svh"

module usb_rx_tb;

	localparam int CLKS = `USB_CLKS_PER_BIT;
	localparam int VEC_DEPTH = 256;
	localparam int MAX_PKTS = 32;

	logic                      clk;
	logic                      n_rst;
	logic [`USB_NUM_PORTS-1:0] d_pin;
	logic                      byte_valid;
	logic [7:0]                byte_data;
	logic [1:0]                byte_port;

	logic [7:0]  vec_mem [0:VEC_DEPTH-1];
	int          pkt_port [MAX_PKTS];
	int          pkt_first [MAX_PKTS];
	int          pkt_len [MAX_PKTS];
	int          pkt_tail [MAX_PKTS];
	int          pkt_gap [MAX_PKTS];
	int          num_pkts;
	int          total_bytes;
	int          cycle_limit = 0;
	int          cycles = 0;
	logic [31:0] lfsr;

	usb_rx_top dut0 (
		.clk        (clk),
		.n_rst      (n_rst),
		.d_pin      (d_pin),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_port  (byte_port)
	);

	usb_rx_checker u_checker (
		.clk        (clk),
		.n_rst      (n_rst),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.byte_port  (byte_port)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit, lsb taken as the bit
	task automatic draw_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic load_vectors();
		int idx;
		idx = 0;
		num_pkts = 0;
		total_bytes = 0;
		$readmemh("test/usb_rx_vectors.txt", vec_mem);
		while (idx < VEC_DEPTH - 3 && vec_mem[idx] != 8'hff && num_pkts < MAX_PKTS) begin
			pkt_port[num_pkts] = int'(vec_mem[idx]);
			pkt_len[num_pkts] = int'(vec_mem[idx + 1]);
			pkt_tail[num_pkts] = int'(vec_mem[idx + 2]);
			pkt_first[num_pkts] = idx + 3;
			total_bytes += pkt_len[num_pkts];
			idx += 3 + pkt_len[num_pkts];
			num_pkts++;
		end
	endtask

	task automatic hold_level(input int p, input logic level);
		@(posedge clk);
		d_pin[p] <= level;
		repeat (CLKS - 1) @(posedge clk);
	endtask

	// LSB first, NRZI, a stuffed 0 after six 1s in a row
	task automatic send_packet(input int k);
		int         ones;
		logic       level;
		logic [7:0] b;
		ones = 0;
		level = 1'b1;
		for (int j = 0; j < pkt_len[k]; j++)
			u_checker.expect_byte(2'(pkt_port[k]), vec_mem[pkt_first[k] + j],
				$sformatf("packet %0d", k));
		for (int j = 0; j < pkt_len[k]; j++) begin
			b = vec_mem[pkt_first[k] + j];
			for (int i = 0; i < 8; i++) begin
				level = b[i] ? level : ~level;
				hold_level(pkt_port[k], level);
				ones = b[i] ? ones + 1 : 0;
				if (ones == `USB_STUFF_LIMIT) begin
					level = ~level;
					hold_level(pkt_port[k], level);
					ones = 0;
				end
			end
		end
		repeat (pkt_tail[k]) begin
			level = ~level;
			hold_level(pkt_port[k], level);
		end
		// Back to idle J, well past the end-of-packet timeout
		repeat (`USB_IDLE_BITS + 2) hold_level(pkt_port[k], 1'b1);
	endtask

	task automatic drive_port(input int p);
		for (int k = 0; k < num_pkts; k++) begin
			if (pkt_port[k] == p) begin
				repeat (pkt_gap[k]) @(posedge clk);
				send_packet(k);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		n_rst <= 1'b0;
		d_pin <= '1;
		lfsr = 32'h30d7;
		load_vectors();
		for (int k = 0; k < num_pkts; k++)
			draw_bits(6, pkt_gap[k]);
		cycle_limit = 64 * total_bytes + 2000;
		repeat (16) @(posedge clk);
		n_rst <= 1'b1;
		// Quiet lines first, any byte seen here is unexpected
		repeat (25 * CLKS) @(posedge clk);
		fork
			drive_port(0);
			drive_port(1);
			drive_port(2);
			drive_port(3);
		join
		while (u_checker.outstanding() != 0)
			@(posedge clk);
		repeat (2 * CLKS) @(posedge clk);
		if (num_pkts == 0)
			$display("vector file held no packets");
		u_checker.print_counts();
		if (num_pkts != 0 && u_checker.error_total() == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with bytes still outstanding", cycles);
		u_checker.report_leftovers();
		u_checker.print_counts();
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* test/usb_rx_vectors.txt */
// port, byte count, trailing zero bits, then the bytes; all hex, ff ends the list
// Each packet opens with sync byte 80 so its first bit is a J to K edge
00 04 00 80 a5 3c 12
01 04 00 80 ff 7e 01
// One stray bit after 2d that returns the line to J, the lane drops it
02 02 01 80 2d
03 03 00 80 c3 5a
00 03 00 80 fe 00
01 05 00 80 ff ff ff 7f
02 03 00 80 e7 18
03 04 00 80 11 22 44
00 02 00 80 96
02 04 00 80 7e 7e 81
ff

/* tb.f */
+incdir+src
src/usb_rx_pkg.sv
src/line_sync.sv
src/rx_bit_timer.sv
src/rx_lane.sv
src/byte_collector.sv
src/usb_rx_top.sv
test/usb_rx_checker.sv
test/usb_rx_tb.sv

/* Makefile */
# Verilator build and run for the USB receive front end testbench
VERILATOR ?= verilator
TOP       ?= usb_rx_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the run prints the pass message on a line of its own
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
